//--- frontend_top.f
logic/fe_types_pkg.sv
logic/issue_rules_pkg.sv
logic/fetch_aligner.sv
logic/instr_buffer.sv
logic/dual_issue_picker.sv
logic/frontend_top.sv
tests/tb_frontend_top.sv

//--- logic/dual_issue_picker.sv
`timescale 1ns/1ps

module dual_issue_picker
  import fe_types_pkg::*;
  import issue_rules_pkg::*;
#(
  parameter int IB_DEPTH = 16
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush,
  input  logic                      issue_stall,
  input  instr_t                    head0,
  input  instr_t                    head1,
  input  logic [$clog2(IB_DEPTH):0] ib_count,
  output pop_cnt_t                  pop_num,
  output logic                      issue_valid0,
  output logic                      issue_valid1,
  output instr_t                    issue_instr0,
  output instr_t                    issue_instr1
);

  localparam int cnt_w = $clog2(IB_DEPTH) + 1;

  opcode_t  h0_opc;
  opcode_t  h1_opc;
  reg_idx_t h0_rd;
  reg_idx_t h1_rs1;
  reg_idx_t h1_rs2;
  logic     h0_ctrl;
  logic     h0_mem;
  logic     h1_mem;
  logic     raw_dep;
  logic     can_pair;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Field decode

  assign h0_opc = head0[opc_msb:opc_lsb];
  assign h1_opc = head1[opc_msb:opc_lsb];
  assign h0_rd  = head0[rd_msb:rd_lsb];
  assign h1_rs1 = head1[rs1_msb:rs1_lsb];
  assign h1_rs2 = head1[rs2_msb:rs2_lsb];

  assign h0_ctrl = (h0_opc == opc_branch) || (h0_opc == opc_jal) || (h0_opc == opc_jalr);
  assign h0_mem  = (h0_opc == opc_load) || (h0_opc == opc_store);
  assign h1_mem  = (h1_opc == opc_load) || (h1_opc == opc_store);

  // x0 never carries a dependence
  assign raw_dep = (h0_rd != '0) && ((h0_rd == h1_rs1) || (h0_rd == h1_rs2));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pairing rule and pop count

  assign can_pair = (ib_count >= cnt_w'(2)) && !h0_ctrl && !(h0_mem && h1_mem) && !raw_dep;

  always_comb begin
    if (issue_stall || (ib_count == '0)) begin
      pop_num = '0;
    end else if (can_pair) begin
      pop_num = pop_cnt_t'(2);
    end else begin
      pop_num = pop_cnt_t'(1);
    end
  end

  // Issue slots load on the same edge that pops the heads
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      issue_valid0 <= 1'b0;
      issue_valid1 <= 1'b0;
    end else begin
      issue_valid0 <= (pop_num != '0);
      issue_valid1 <= (pop_num == pop_cnt_t'(2));
    end
  end

  always_ff @(posedge clk) begin
    if (pop_num != '0) begin
      issue_instr0 <= head0;
      issue_instr1 <= head1;
    end
  end

  a_slot1_needs_slot0: assert property (
    @(posedge clk) disable iff (!rst_n)
    issue_valid1 |-> issue_valid0
  ) else $error("slot 1 issued without slot 0");

endmodule

//--- logic/fe_types_pkg.sv
package fe_types_pkg;

  // One instruction word as it travels from fetch to issue
  localparam int instr_w = 32;
  typedef logic [instr_w-1:0] instr_t;

  // A fetch packet is four words, word 0 in the lowest bits
  localparam int fetch_width = 4;
  typedef instr_t [fetch_width-1:0] fetch_pkt_t;

  // Valid words in a packet run from 0 to fetch_width
  localparam int push_cnt_w = 3;
  typedef logic [push_cnt_w-1:0] push_cnt_t;

  // Up to two entries leave the buffer head per cycle
  localparam int pop_cnt_w = 2;
  typedef logic [pop_cnt_w-1:0] pop_cnt_t;

  localparam int max_pop = 2;

endpackage

//--- logic/fetch_aligner.sv
`timescale 1ns/1ps

module fetch_aligner
  import fe_types_pkg::*;
#(
  parameter int IB_DEPTH = 16
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush,
  input  logic                      fetch_valid,
  input  fetch_pkt_t                fetch_pkt,
  input  push_cnt_t                 fetch_cnt,
  input  logic [$clog2(IB_DEPTH):0] ib_count,
  output logic                      fetch_ready,
  output fetch_pkt_t                push_words,
  output push_cnt_t                 push_num
);

  localparam int cnt_w = $clog2(IB_DEPTH) + 1;

  logic       held_q;
  push_cnt_t  held_cnt_q;
  fetch_pkt_t pkt_q;
  logic       accept;
  logic       fits;
  logic       push_fire;
  logic [cnt_w-1:0] free_slots;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Hold stage

  assign fetch_ready = !held_q;
  assign accept      = fetch_valid && fetch_ready;

  // Pops during the same cycle only add room, so the current count is safe
  assign free_slots = cnt_w'(IB_DEPTH) - ib_count;
  assign fits       = free_slots >= cnt_w'(held_cnt_q);
  assign push_fire  = held_q && fits;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      held_q     <= 1'b0;
      held_cnt_q <= '0;
    end else if (accept) begin
      // An empty packet is taken and dropped on the spot
      held_q     <= (fetch_cnt != '0);
      held_cnt_q <= fetch_cnt;
    end else if (push_fire) begin
      held_q     <= 1'b0;
      held_cnt_q <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pkt_q <= fetch_pkt;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Push side

  assign push_words = pkt_q;
  assign push_num   = push_fire ? held_cnt_q : '0;

  a_fetch_cnt_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    fetch_valid |-> (fetch_cnt <= push_cnt_t'(fetch_width))
  ) else $error("fetch_cnt above packet width");

endmodule

//--- logic/frontend_top.sv
`timescale 1ns/1ps

module frontend_top
  import fe_types_pkg::*;
#(
  parameter int IB_DEPTH = 16
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush,
  input  logic                      fetch_valid,
  input  fetch_pkt_t                fetch_pkt,
  input  push_cnt_t                 fetch_cnt,
  input  logic                      issue_stall,
  output logic                      fetch_ready,
  output logic                      issue_valid0,
  output logic                      issue_valid1,
  output instr_t                    issue_instr0,
  output instr_t                    issue_instr1,
  output logic [$clog2(IB_DEPTH):0] ib_count,
  output logic                      ib_empty
);

  fetch_pkt_t push_words;
  push_cnt_t  push_num;
  pop_cnt_t   pop_num;
  instr_t     head0;
  instr_t     head1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fetch, buffer and issue stages

  fetch_aligner #(
    .IB_DEPTH(IB_DEPTH)
  ) aligner_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .fetch_valid(fetch_valid),
    .fetch_pkt  (fetch_pkt),
    .fetch_cnt  (fetch_cnt),
    .ib_count   (ib_count),
    .fetch_ready(fetch_ready),
    .push_words (push_words),
    .push_num   (push_num)
  );

  instr_buffer #(
    .IB_DEPTH(IB_DEPTH)
  ) buffer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .push_words(push_words),
    .push_num  (push_num),
    .pop_num   (pop_num),
    .head0     (head0),
    .head1     (head1),
    .ib_count  (ib_count),
    .ib_empty  (ib_empty)
  );

  dual_issue_picker #(
    .IB_DEPTH(IB_DEPTH)
  ) picker_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .issue_stall (issue_stall),
    .head0       (head0),
    .head1       (head1),
    .ib_count    (ib_count),
    .pop_num     (pop_num),
    .issue_valid0(issue_valid0),
    .issue_valid1(issue_valid1),
    .issue_instr0(issue_instr0),
    .issue_instr1(issue_instr1)
  );

endmodule

//--- logic/instr_buffer.sv
`timescale 1ns/1ps

module instr_buffer
  import fe_types_pkg::*;
#(
  parameter int IB_DEPTH = 16
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush,
  input  fetch_pkt_t                push_words,
  input  push_cnt_t                 push_num,
  input  pop_cnt_t                  pop_num,
  output instr_t                    head0,
  output instr_t                    head1,
  output logic [$clog2(IB_DEPTH):0] ib_count,
  output logic                      ib_empty
);

  localparam int ptr_w = $clog2(IB_DEPTH);
  localparam int cnt_w = ptr_w + 1;

  typedef logic [ptr_w-1:0] ptr_t;

  instr_t           mem [IB_DEPTH];
  ptr_t             head_ptr;
  ptr_t             tail_ptr;
  logic [cnt_w-1:0] count_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Entry array

  // Word i of the packet lands i slots past the tail, wrapping at IB_DEPTH
  always_ff @(posedge clk) begin
    for (int i = 0; i < fetch_width; i++) begin
      if (push_cnt_t'(i) < push_num) begin
        mem[tail_ptr + ptr_t'(i)] <= push_words[i];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pointers and fill count

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count_q  <= '0;
    end else begin
      tail_ptr <= tail_ptr + ptr_t'(push_num);
      head_ptr <= head_ptr + ptr_t'(pop_num);
      count_q  <= count_q + cnt_w'(push_num) - cnt_w'(pop_num);
    end
  end

  // head1 is stale when only one entry is present; the picker checks the count
  assign head0 = mem[head_ptr];
  assign head1 = mem[head_ptr + ptr_t'(1)];

  assign ib_count = count_q;
  assign ib_empty = (count_q == '0);

  // The aligner only pushes into free room, so the count stays bounded
  a_count_bound: assert property (
    @(posedge clk) disable iff (!rst_n)
    count_q <= cnt_w'(IB_DEPTH)
  ) else $error("instruction buffer count above depth");

  // The picker never pops more entries than the buffer holds
  a_pop_bound: assert property (
    @(posedge clk) disable iff (!rst_n || flush)
    (pop_num <= pop_cnt_t'(max_pop)) && (cnt_w'(pop_num) <= count_q)
  ) else $error("pop_num exceeds buffer count");

endmodule

//--- logic/issue_rules_pkg.sv
package issue_rules_pkg;

  typedef logic [6:0] opcode_t;
  typedef logic [4:0] reg_idx_t;

  // Memory class
  localparam opcode_t opc_load   = 7'b0000011;
  localparam opcode_t opc_store  = 7'b0100011;

  // Control class opcodes make head0 issue alone
  localparam opcode_t opc_branch = 7'b1100011;
  localparam opcode_t opc_jal    = 7'b1101111;
  localparam opcode_t opc_jalr   = 7'b1100111;

  // Field positions inside a 32-bit word
  localparam int opc_lsb = 0;
  localparam int opc_msb = 6;
  localparam int rd_lsb  = 7;
  localparam int rd_msb  = 11;
  localparam int rs1_lsb = 15;
  localparam int rs1_msb = 19;
  localparam int rs2_lsb = 20;
  localparam int rs2_msb = 24;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the front-end testbench with Verilator.
# Run from the project root.

set -u

build_dir=build
log_file=sim.log

verilator --binary --timing --assert \
  --top-module tb_frontend_top \
  --Mdir "$build_dir" \
  -f frontend_top.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$build_dir/Vtb_frontend_top" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" "$log_file"; then
  exit 0
fi
echo "Pass message not found in $log_file"
exit 1

//--- tests/frontend_stimulus.txt
# kind(P packet, F flush) count word0 word1 word2 word3 slot0 slot1 slot2 slot3
# Slot code 0 issues in slot 0, 1 pairs in slot 1; codes past count are ignored
# Section 1: RAW-free pairs, load/store split, branch alone, last word alone
P 4 00000093 00000113 002081b3 00040393 0 1 0 1
P 3 00028203 00628023 00050493 00000000 0 0 1 0
P 4 00208063 00000093 0000006f 00000013 0 0 1 0
# Words of this packet are flushed and never issue
F 4 00000113 002081b3 00028203 00628023 0 0 0 0
# Section 2: a dependence on x1 splits the pair
P 2 00040393 00050493 00000000 00000000 0 1 0 0
P 4 00000093 002081b3 00000013 00028203 0 0 1 0
P 1 0000006f 00000000 00000000 00000000 1 0 0 0
F 2 00000093 00000113 00000000 00000000 0 0 0 0
# Section 3: memory pairs refused, rd x0 never blocks a pair
P 4 00028203 00028203 00028203 00628023 0 0 0 0
P 3 0000006f 00008013 00000093 00000000 1 0 1 0

//--- tests/tb_frontend_top.sv
`timescale 1ns/1ps

module tb_frontend_top
  import fe_types_pkg::*;
;

  localparam int IB_DEPTH = 16;
  localparam int timeout_cycles = 400;

  logic clk, rst_n, flush, fetch_valid, issue_stall;
  fetch_pkt_t fetch_pkt;
  push_cnt_t fetch_cnt;
  logic fetch_ready, issue_valid0, issue_valid1, ib_empty;
  instr_t issue_instr0, issue_instr1;
  logic [$clog2(IB_DEPTH):0] ib_count;

  // Stimulus lines and the reference model of words still to be issued
  byte kind_a[$];
  int cnt_a[$];
  fetch_pkt_t pkt_a[$];
  int slot_a[$];
  logic [31:0] model_q[$];
  int slot_q[$];

  int errors = 0;
  int pushed_total = 0;
  int issued_total = 0;
  integer seed = 43625;
  bit random_mode = 0;

  frontend_top #(.IB_DEPTH(IB_DEPTH)) dut_i (
    .clk(clk), .rst_n(rst_n), .flush(flush), .fetch_valid(fetch_valid),
    .fetch_pkt(fetch_pkt), .fetch_cnt(fetch_cnt), .issue_stall(issue_stall),
    .fetch_ready(fetch_ready), .issue_valid0(issue_valid0), .issue_valid1(issue_valid1),
    .issue_instr0(issue_instr0), .issue_instr1(issue_instr1),
    .ib_count(ib_count), .ib_empty(ib_empty)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_eq(input longint got, input longint exp, input string msg);
    if (got != exp) begin
      errors++;
      $display("FAIL t=%0t %s: got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("Run stopped: %s", msg);
    $display("tests failed");
    $finish;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pairing rule as seen from the issue ports

  function automatic bit pair_allowed(input logic [31:0] w0, input logic [31:0] w1);
    logic [6:0] op0;
    logic [6:0] op1;
    bit ctrl0;
    bit mem0;
    bit mem1;
    bit dep;
    op0 = w0[6:0];
    op1 = w1[6:0];
    ctrl0 = (op0 == 7'h63) || (op0 == 7'h6f) || (op0 == 7'h67);
    mem0 = (op0 == 7'h03) || (op0 == 7'h23);
    mem1 = (op1 == 7'h03) || (op1 == 7'h23);
    dep = (w0[11:7] != 5'd0) && ((w0[11:7] == w1[19:15]) || (w0[11:7] == w1[24:20]));
    return !ctrl0 && !(mem0 && mem1) && !dep;
  endfunction

  task automatic take_issued(input logic [31:0] word, input int slot);
    if (model_q.size() == 0) begin
      errors++;
      $display("Word %h was issued with no word outstanding", word);
    end else begin
      check_eq(longint'(word), longint'(model_q[0]), "issued word order");
      if (slot_q[0] >= 0) begin
        check_eq(slot, slot_q[0], "issue slot of word");
      end
      void'(model_q.pop_front());
      void'(slot_q.pop_front());
      issued_total++;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      if (issue_valid1 && !issue_valid0) begin
        errors++;
        $display("Slot 1 was valid without slot 0");
      end
      if (issue_valid0) begin
        take_issued(issue_instr0, 0);
      end
      if (issue_valid1) begin
        take_issued(issue_instr1, 1);
        check_eq(pair_allowed(issue_instr0, issue_instr1), 1, "pair breaks rule");
      end
    end
  end

  always @(negedge clk) begin
    if (random_mode) begin
      issue_stall = (($random(seed) & 3) == 0);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Waits and drivers

  task automatic wait_fetch_ready();
    int n;
    n = 0;
    while (!fetch_ready) begin
      @(negedge clk);
      n++;
      if (n > timeout_cycles) abort_run("fetch_ready stayed low past the timeout");
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (model_q.size() != 0) begin
      @(negedge clk);
      n++;
      if (n > timeout_cycles) abort_run("outstanding words were not issued before the timeout");
    end
  endtask

  task automatic send_packet(input int idx, input bit use_slots);
    wait_fetch_ready();
    fetch_pkt = pkt_a[idx];
    fetch_cnt = 3'(cnt_a[idx]);
    fetch_valid = 1'b1;
    for (int i = 0; i < cnt_a[idx]; i++) begin
      model_q.push_back(pkt_a[idx][i]);
      slot_q.push_back(use_slots ? slot_a[idx*4+i] : -1);
    end
    pushed_total += cnt_a[idx];
    @(negedge clk);
    fetch_valid = 1'b0;
  endtask

  // With the stall held, the buffer count follows the model exactly
  task automatic check_count();
    check_eq(longint'(ib_count), model_q.size(), "ib_count against model");
    check_eq(longint'(ib_empty), (model_q.size() == 0), "ib_empty against model");
  endtask

  task automatic release_section();
    issue_stall = 1'b0;
    wait_drained();
    @(negedge clk);
    issue_stall = 1'b1;
  endtask

  task automatic read_stimulus();
    int fd;
    int rc;
    string line;
    byte kind;
    int cnt;
    logic [31:0] w0, w1, w2, w3;
    int s0, s1, s2, s3;
    fd = $fopen("tests/frontend_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("stimulus file could not be opened");
    end else begin
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        if (rc > 1 && line[0] != 8'h23) begin
          rc = $sscanf(line, "%c %d %h %h %h %h %d %d %d %d",
                       kind, cnt, w0, w1, w2, w3, s0, s1, s2, s3);
          if (rc == 10) begin
            kind_a.push_back(kind);
            cnt_a.push_back(cnt);
            pkt_a.push_back({w3, w2, w1, w0});
            slot_a.push_back(s0);
            slot_a.push_back(s1);
            slot_a.push_back(s2);
            slot_a.push_back(s3);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence

  initial begin
    int p_idx[$];
    int n;
    int k;
    bit full;
    rst_n = 1'b0;
    flush = 1'b0;
    fetch_valid = 1'b0;
    fetch_pkt = '0;
    fetch_cnt = '0;
    issue_stall = 1'b1;
    read_stimulus();
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_eq(fetch_ready, 1, "fetch_ready after reset");
    check_eq(issue_valid0, 0, "issue_valid0 after reset");
    check_eq(issue_valid1, 0, "issue_valid1 after reset");
    check_eq(longint'(ib_count), 0, "ib_count after reset");
    check_eq(ib_empty, 1, "ib_empty after reset");

    // Fill-first sections end at a flush line or at the end of the file
    for (int i = 0; i < kind_a.size(); i++) begin
      if (kind_a[i] == 8'h50) begin
        p_idx.push_back(i);
        send_packet(i, 1'b1);
        wait_fetch_ready();
        check_count();
      end else begin
        release_section();
        send_packet(i, 1'b0);
        wait_fetch_ready();
        check_count();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_eq(longint'(ib_count), 0, "ib_count after flush");
        check_eq(ib_empty, 1, "ib_empty after flush");
        pushed_total -= model_q.size();
        model_q.delete();
        slot_q.delete();
      end
    end
    release_section();

    // Random stall over the same packets
    random_mode = 1'b1;
    for (int i = 0; i < p_idx.size(); i++) begin
      send_packet(p_idx[i], 1'b0);
    end
    wait_drained();
    random_mode = 1'b0;
    issue_stall = 1'b1;

    // Back-pressure until the aligner holds a packet it cannot push
    full = 1'b0;
    n = 0;
    while (!full && n < 40) begin
      send_packet(p_idx[n % p_idx.size()], 1'b0);
      k = 0;
      while (!fetch_ready && k < 6) begin
        @(negedge clk);
        k++;
      end
      if (!fetch_ready) begin
        full = 1'b1;
      end else begin
        check_count();
      end
      n++;
    end
    if (!full) begin
      errors++;
      $display("fetch_ready never dropped while the buffer was stalled");
    end
    check_eq(ib_count > IB_DEPTH - 4, 1, "ib_count low when fetch stalled");
    check_eq(ib_count <= IB_DEPTH, 1, "ib_count above depth");
    issue_stall = 1'b0;
    wait_drained();
    repeat (4) @(negedge clk);
    check_eq(issued_total, pushed_total, "total issued against total pushed");

    $display("Errors: %0d, words pushed: %0d, words issued: %0d",
             errors, pushed_total, issued_total);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
